// File: bench/uartTb.sv
`timescale 1ns/100ps

module uartTb;

    localparam int BitClks = 8;
    localparam int TotalBytes = 49;
    localparam int WatchdogNs = TotalBytes * 10 * BitClks * 10 * 3 + 5000;
    localparam int TxDonePolls = 3000;
    localparam uartPkg::avAddr_t CtrlAddr = uartPkg::avAddr_t'(uartPkg::RegAddrCtrl);
    localparam uartPkg::avAddr_t DataAddr = uartPkg::avAddr_t'(uartPkg::RegAddrData);
    localparam uartPkg::avAddr_t UnmappedAddr = uartPkg::avAddr_t'(2);
    localparam uartPkg::avAddr_t OtherSelAddr =
        uartPkg::avAddr_t'(1) << (uartPkg::AvAddrBits - uartPkg::PeriphSelBits);

    logic clk;
    logic rstN;
    uartPkg::avAddr_t avAddr;
    uartPkg::avByteEn_t avByteEn;
    logic avRdEn;
    logic avWrEn;
    uartPkg::avData_t avWriteData;
    uartPkg::avData_t avReadData;
    logic uartTx;
    logic nCts;
    logic uartRx;
    logic nRts;
    logic forceRxHigh;

    // Check strobes and reference values seen by the assertions
    logic rdCheck = 1'b0;
    uartPkg::avData_t rdMask = '0;
    uartPkg::avData_t rdExpect = '0;
    logic holdQuiet = 1'b0;
    logic rtsCheck = 1'b0;
    logic rtsExpect = 1'b0;
    logic drainCheck = 1'b0;
    int txPending = 0;
    logic monDone = 1'b0;
    logic monStart = 1'b0;
    logic monStop = 1'b1;
    logic monSpurious = 1'b0;
    uartPkg::byte_t monByte = '0;
    uartPkg::byte_t monExpect = '0;
    int framesSeen = 0;
    int monBit;
    logic [7:0] lfsr = 8'd63;

    uartPkg::byte_t expTx[$];
    uartPkg::byte_t expRx[$];

    uartTop #(
        .PeriphSelVal ('0)
    ) dut_i (
        .i_Clk         (clk),
        .i_rstN        (rstN),
        .i_avAddr      (avAddr),
        .i_avByteEn    (avByteEn),
        .i_avRead      (avRdEn),
        .i_avWrite     (avWrEn),
        .i_avWriteData (avWriteData),
        .o_avReadData  (avReadData),
        .o_UartTx      (uartTx),
        .i_UartNcts    (nCts),
        .i_UartRx      (uartRx),
        .o_UartNrts    (nRts)
    );

    // Serial loopback
    assign uartRx = forceRxHigh ? 1'b1 : uartTx;

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic abortRun(input string line);
        $display("%s", line);
        $display("TB FAILED");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    initial begin
        #(WatchdogNs);
        abortRun("Watchdog expired before the tests finished");
    end

    // x^8 + x^6 + x^5 + x^4 + 1
    function automatic logic [7:0] lfsrStep(input logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    function automatic uartPkg::avData_t bitMask(input int pos);
        return uartPkg::avData_t'(1) << pos;
    endfunction

    function automatic uartPkg::avData_t ctrlWord(input int clks, input logic txOn,
                                                  input logic rxOn, input logic fcOn);
        uartPkg::avData_t w;
        w = '0;
        w[uartPkg::CtrlClksLsb +: uartPkg::ClksBits] = clks;
        w[uartPkg::CtrlTxEnBit] = txOn;
        w[uartPkg::CtrlRxEnBit] = rxOn;
        w[uartPkg::CtrlFcEnBit] = fcOn;
        return w;
    endfunction

    task automatic nextPayload(output uartPkg::byte_t value);
        for (int i = 0; i < 8; i++) begin
            lfsr = lfsrStep(lfsr);
            value[i] = lfsr[0];
        end
    endtask

    task automatic idleCycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic avWrite(input uartPkg::avAddr_t addr, input uartPkg::avByteEn_t be,
                           input uartPkg::avData_t data);
        avAddr = addr;
        avByteEn = be;
        avWriteData = data;
        avWrEn = 1'b1;
        @(posedge clk);
        #1;
        avWrEn = 1'b0;
    endtask

    task automatic avRead(input uartPkg::avAddr_t addr, input logic check,
                          input uartPkg::avData_t mask, input uartPkg::avData_t expValue,
                          output uartPkg::avData_t value);
        avAddr = addr;
        avRdEn = 1'b1;
        rdCheck = check;
        rdMask = mask;
        rdExpect = expValue;
        @(posedge clk);
        #1;
        avRdEn = 1'b0;
        rdCheck = 1'b0;
        value = avReadData;
    endtask

    task automatic readCheck(input uartPkg::avAddr_t addr, input uartPkg::avData_t mask,
                             input uartPkg::avData_t expValue);
        uartPkg::avData_t unused;
        avRead(addr, 1'b1, mask, expValue, unused);
    endtask

    task automatic queueTxByte(input logic expectRx);
        uartPkg::byte_t b;
        nextPayload(b);
        avWrite(DataAddr, 4'b0001, uartPkg::avData_t'(b));
        expTx.push_back(b);
        if (expectRx) begin
            expRx.push_back(b);
        end
    endtask

    task automatic waitTxDone();
        uartPkg::avData_t status;
        int polls;
        polls = 0;
        do begin
            avRead(CtrlAddr, 1'b0, '0, '0, status);
            polls++;
            if (polls > TxDonePolls) begin
                abortRun("Transmitter never reported done");
            end
        end while (!status[uartPkg::StatTxDoneBit]);
    endtask

    task automatic waitFrames(input int target);
        int waited;
        waited = 0;
        while (framesSeen < target) begin
            idleCycles(1);
            waited++;
            if (waited > 20 * BitClks) begin
                abortRun("No serial frame arrived in time");
            end
        end
    endtask

    task automatic pulseRtsCheck(input logic level);
        rtsExpect = level;
        rtsCheck = 1'b1;
        idleCycles(1);
        rtsCheck = 1'b0;
    endtask

    task automatic pulseDrainCheck();
        txPending = expTx.size();
        drainCheck = 1'b1;
        idleCycles(1);
        drainCheck = 1'b0;
    endtask

    // Decodes o_UartTx at the programmed bit period
    always begin
        @(posedge clk);
        if (rstN && !uartTx) begin
            repeat (BitClks / 2 - 1) @(posedge clk);
            monStart = uartTx;
            for (monBit = 0; monBit < 8; monBit++) begin
                repeat (BitClks) @(posedge clk);
                monByte[monBit] = uartTx;
            end
            repeat (BitClks) @(posedge clk);
            monStop = uartTx;
            monSpurious = (expTx.size() == 0);
            if (!monSpurious) begin
                monExpect = expTx.pop_front();
            end
            framesSeen++;
            monDone = 1'b1;
            @(posedge clk);
            monDone = 1'b0;
        end
    end

    resetState: assert property (
        @(posedge clk) $rose(rstN) |-> uartTx && !nRts && avReadData == '0
    ) else abortRun($sformatf("FAIL %0t: outputs not idle after reset", $time));

    readData: assert property (
        @(posedge clk) disable iff (!rstN)
        rdCheck |=> ((avReadData & $past(rdMask)) == $past(rdExpect))
    ) else abortRun($sformatf("FAIL %0t: read data %h, expected %h under mask %h",
                              $time, avReadData, $past(rdExpect), $past(rdMask)));

    frameCheck: assert property (
        @(posedge clk) disable iff (!rstN)
        monDone |-> !monSpurious && !monStart && monStop && monByte == monExpect
    ) else abortRun($sformatf("FAIL %0t: serial frame %h, expected %h (extra %b)",
                              $time, monByte, monExpect, monSpurious));

    quietLine: assert property (
        @(posedge clk) disable iff (!rstN)
        holdQuiet |-> uartTx
    ) else abortRun($sformatf("FAIL %0t: TX line active while CTS holds it off", $time));

    rtsLevel: assert property (
        @(posedge clk) disable iff (!rstN)
        rtsCheck |-> nRts == rtsExpect
    ) else abortRun($sformatf("FAIL %0t: nRTS is %b, expected %b", $time, nRts, rtsExpect));

    txDrained: assert property (
        @(posedge clk) disable iff (!rstN)
        drainCheck |-> txPending == 0
    ) else abortRun($sformatf("FAIL %0t: %0d bytes never sent", $time, txPending));

    initial begin
        int base;
        rstN = 1'b0;
        avAddr = '0;
        avByteEn = '0;
        avRdEn = 1'b0;
        avWrEn = 1'b0;
        avWriteData = '0;
        nCts = 1'b0;
        forceRxHigh = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        rstN = 1'b1;
        idleCycles(2);

        // Reset values and byte-enable writes
        readCheck(CtrlAddr, '1,
            uartPkg::avData_t'(uartPkg::DefaultClksPerBit) | bitMask(uartPkg::StatTxDoneBit));
        avWrite(CtrlAddr, 4'b0001, 32'h0023_AA05);
        readCheck(CtrlAddr, '1, 32'h0000_0005 | bitMask(uartPkg::StatTxDoneBit));
        avWrite(CtrlAddr, 4'b0010, 32'h0000_0100);
        readCheck(CtrlAddr, '1, 32'h0000_0105 | bitMask(uartPkg::StatTxDoneBit));
        avWrite(CtrlAddr, 4'b0100, bitMask(uartPkg::CtrlRxEnBit));
        readCheck(CtrlAddr, '1, 32'h0000_0105 | bitMask(uartPkg::CtrlRxEnBit)
                              | bitMask(uartPkg::StatTxDoneBit));
        readCheck(OtherSelAddr, '1, '0);
        readCheck(UnmappedAddr, '1, '0);

        // Transmit framing, RX input held high
        forceRxHigh = 1'b1;
        avWrite(CtrlAddr, 4'b0111, ctrlWord(BitClks, 1'b1, 1'b1, 1'b0));
        repeat (6) queueTxByte(1'b0);
        waitTxDone();
        pulseDrainCheck();
        readCheck(CtrlAddr, bitMask(uartPkg::StatTxDoneBit) | bitMask(uartPkg::StatRxAvailBit),
                  bitMask(uartPkg::StatTxDoneBit));

        // Loopback receive
        forceRxHigh = 1'b0;
        repeat (4) queueTxByte(1'b1);
        waitTxDone();
        idleCycles(4);
        pulseDrainCheck();
        readCheck(CtrlAddr, bitMask(uartPkg::StatRxAvailBit), bitMask(uartPkg::StatRxAvailBit));
        while (expRx.size() > 0) begin
            readCheck(DataAddr, '1, uartPkg::avData_t'(expRx.pop_front()));
        end
        readCheck(DataAddr, '1, '0);
        readCheck(CtrlAddr, bitMask(uartPkg::StatRxAvailBit), '0);

        // CTS hold-off
        nCts = 1'b1;
        idleCycles(4);
        avWrite(CtrlAddr, 4'b0111, ctrlWord(BitClks, 1'b1, 1'b0, 1'b1));
        repeat (3) queueTxByte(1'b0);
        holdQuiet = 1'b1;
        idleCycles(200);
        readCheck(CtrlAddr, bitMask(uartPkg::StatTxDoneBit), '0);
        holdQuiet = 1'b0;
        nCts = 1'b0;
        waitTxDone();
        pulseDrainCheck();
        nCts = 1'b1;
        avWrite(CtrlAddr, 4'b0111, ctrlWord(BitClks, 1'b1, 1'b0, 1'b0));
        repeat (2) queueTxByte(1'b0);
        waitTxDone();
        pulseDrainCheck();
        nCts = 1'b0;

        // RTS threshold and RX overflow
        avWrite(CtrlAddr, 4'b0111, ctrlWord(BitClks, 1'b1, 1'b1, 1'b1));
        base = framesSeen;
        for (int i = 0; i < 17; i++) begin
            queueTxByte(i < uartPkg::FifoDepth);
        end
        for (int k = 1; k <= 17; k++) begin
            waitFrames(base + k);
            idleCycles(6);
            pulseRtsCheck(k >= uartPkg::RxProgFullThreshold);
        end
        waitTxDone();
        pulseDrainCheck();
        avWrite(CtrlAddr, 4'b0100, ctrlWord(BitClks, 1'b1, 1'b1, 1'b0));
        pulseRtsCheck(1'b0);
        avWrite(CtrlAddr, 4'b0100, ctrlWord(BitClks, 1'b1, 1'b1, 1'b1));
        pulseRtsCheck(1'b1);
        for (int held = uartPkg::FifoDepth - 1; held >= 0; held--) begin
            readCheck(DataAddr, '1, uartPkg::avData_t'(expRx.pop_front()));
            pulseRtsCheck(held >= uartPkg::RxProgFullThreshold);
        end
        readCheck(DataAddr, '1, '0);
        readCheck(CtrlAddr, bitMask(uartPkg::StatRxAvailBit), '0);

        // TX FIFO full drops the 17th byte
        avWrite(CtrlAddr, 4'b0111, ctrlWord(BitClks, 1'b0, 1'b0, 1'b0));
        repeat (uartPkg::FifoDepth) queueTxByte(1'b0);
        avWrite(DataAddr, 4'b0001, 32'h0000_00C3);
        readCheck(CtrlAddr, bitMask(uartPkg::StatTxFullBit) | bitMask(uartPkg::StatTxDoneBit),
                  bitMask(uartPkg::StatTxFullBit));
        avWrite(CtrlAddr, 4'b0100, ctrlWord(BitClks, 1'b1, 1'b0, 1'b0));
        waitTxDone();
        idleCycles(2 * BitClks);
        pulseDrainCheck();

        $display("TB PASSED");
        $finish;
    end

endmodule

// File: build.f
source/uartPkg.sv
source/uartFifoIf.sv
source/uartFifo.sv
source/baudTimer.sv
source/uartTx.sv
source/uartRx.sv
source/uartBusInterface.sv
source/uartTop.sv
bench/uartTb.sv

// File: source/baudTimer.sv
`timescale 1ns/100ps

module baudTimer (
    input  logic                 i_Clk,
    input  logic                 i_rstN,
    input  logic                 i_run,
    input  uartPkg::clksPerBit_t i_clksPerBit,
    output logic                 o_midTick,
    output logic                 o_endTick
);

    uartPkg::clksPerBit_t count;
    uartPkg::clksPerBit_t lastCount;
    uartPkg::clksPerBit_t midCount;

    assign lastCount = i_clksPerBit - 1'b1;
    assign midCount = i_clksPerBit >> 1;

    // Held at zero while idle so each frame starts fresh
    always_ff @(posedge i_Clk) begin
        if (!i_rstN) begin
            count <= '0;
        end else if (!i_run || count == lastCount) begin
            count <= '0;
        end else begin
            count <= count + 1'b1;
        end
    end

    assign o_midTick = i_run && (count == midCount);
    assign o_endTick = i_run && (count == lastCount);

endmodule

// File: source/uartBusInterface.sv
`timescale 1ns/100ps

module uartBusInterface #(
    parameter logic [uartPkg::PeriphSelBits-1:0] PeriphSelVal = '0
) (
    input  logic                 i_Clk,
    input  logic                 i_rstN,
    input  uartPkg::avAddr_t     i_avAddr,
    input  uartPkg::avByteEn_t   i_avByteEn,
    input  logic                 i_avRead,
    input  logic                 i_avWrite,
    input  uartPkg::avData_t     i_avWriteData,
    output uartPkg::avData_t     o_avReadData,
    output uartPkg::clksPerBit_t o_clksPerBit,
    output logic                 o_txEn,
    output logic                 o_rxEn,
    output logic                 o_fcEn,
    input  logic                 i_txIdle,
    uartFifoIf.writer            txFifo,
    uartFifoIf.reader            rxFifo
);

    logic slaveSel;
    logic [uartPkg::AvAddrBits-uartPkg::PeriphSelBits-1:0] regAddr;
    logic ctrlWrite;
    logic dataWrite;
    logic ctrlRead;
    logic dataRead;
    uartPkg::avData_t statusWord;

    // Upper address bits pick the peripheral
    assign slaveSel =
        (i_avAddr[uartPkg::AvAddrBits-1 -: uartPkg::PeriphSelBits] == PeriphSelVal);
    assign regAddr = i_avAddr[uartPkg::AvAddrBits-uartPkg::PeriphSelBits-1:0];

    assign ctrlWrite = slaveSel && i_avWrite && (regAddr == uartPkg::RegAddrCtrl);
    assign dataWrite = slaveSel && i_avWrite && (regAddr == uartPkg::RegAddrData);
    assign ctrlRead = slaveSel && i_avRead && (regAddr == uartPkg::RegAddrCtrl);
    assign dataRead = slaveSel && i_avRead && (regAddr == uartPkg::RegAddrData);

    always_ff @(posedge i_Clk) begin
        if (!i_rstN) begin
            o_clksPerBit <= uartPkg::clksPerBit_t'(uartPkg::DefaultClksPerBit);
            o_txEn <= 1'b0;
            o_rxEn <= 1'b0;
            o_fcEn <= 1'b0;
        end else if (ctrlWrite) begin
            if (i_avByteEn[0]) begin
                o_clksPerBit[7:0] <= i_avWriteData[uartPkg::CtrlClksLsb +: 8];
            end
            if (i_avByteEn[1]) begin
                o_clksPerBit[15:8] <= i_avWriteData[uartPkg::CtrlClksLsb + 8 +: 8];
            end
            // Enables all live in byte 2
            if (i_avByteEn[2]) begin
                o_txEn <= i_avWriteData[uartPkg::CtrlTxEnBit];
                o_rxEn <= i_avWriteData[uartPkg::CtrlRxEnBit];
                o_fcEn <= i_avWriteData[uartPkg::CtrlFcEnBit];
            end
        end
    end

    // TX push lands on the write edge itself
    assign txFifo.wrEn = dataWrite && i_avByteEn[0];
    assign txFifo.wrData = i_avWriteData[7:0];
    assign rxFifo.rdEn = dataRead;

    always_comb begin
        statusWord = '0;
        statusWord[uartPkg::CtrlClksLsb +: uartPkg::ClksBits] = o_clksPerBit;
        statusWord[uartPkg::CtrlTxEnBit] = o_txEn;
        statusWord[uartPkg::CtrlRxEnBit] = o_rxEn;
        statusWord[uartPkg::StatTxDoneBit] = txFifo.empty && i_txIdle;
        statusWord[uartPkg::StatTxFullBit] = txFifo.full;
        statusWord[uartPkg::StatRxAvailBit] = !rxFifo.empty;
        statusWord[uartPkg::CtrlFcEnBit] = o_fcEn;
    end

    // Read data one cycle after the request, zero otherwise
    always_ff @(posedge i_Clk) begin
        if (!i_rstN) begin
            o_avReadData <= '0;
        end else if (ctrlRead) begin
            o_avReadData <= statusWord;
        end else if (dataRead && !rxFifo.empty) begin
            o_avReadData <= uartPkg::avData_t'(rxFifo.rdData);
        end else begin
            o_avReadData <= '0;
        end
    end

    noReadWithWrite: assert property (
        @(posedge i_Clk) disable iff (!i_rstN)
        !(i_avRead && i_avWrite)
    ) else $error("Avalon read and write in the same cycle");

endmodule

// File: source/uartFifo.sv
`timescale 1ns/100ps

module uartFifo (
    input  logic      i_Clk,
    input  logic      i_rstN,
    uartFifoIf.sink   wrSide,
    uartFifoIf.source rdSide
);

    uartPkg::byte_t mem [uartPkg::FifoDepth];
    logic [uartPkg::FifoPtrBits-1:0] wrPtr;
    logic [uartPkg::FifoPtrBits-1:0] rdPtr;
    uartPkg::fifoCount_t count;
    uartPkg::fifoCount_t countNext;
    logic doWrite;
    logic doRead;

    // Requests against a full or empty FIFO are ignored
    assign doWrite = wrSide.wrEn && !wrSide.full;
    assign doRead = rdSide.rdEn && !rdSide.empty;

    always_comb begin
        countNext = count;
        if (doWrite && !doRead) begin
            countNext = count + 1'b1;
        end else if (doRead && !doWrite) begin
            countNext = count - 1'b1;
        end
    end

    always_ff @(posedge i_Clk) begin
        if (doWrite) begin
            mem[wrPtr] <= wrSide.wrData;
        end
    end

    always_ff @(posedge i_Clk) begin
        if (!i_rstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
            wrSide.full <= 1'b0;
            rdSide.empty <= 1'b1;
            rdSide.progFull <= 1'b0;
        end else begin
            if (doWrite) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (doRead) begin
                rdPtr <= rdPtr + 1'b1;
            end
            count <= countNext;
            // Flags track the new count
            wrSide.full <= (countNext == uartPkg::FifoDepth);
            rdSide.empty <= (countNext == '0);
            rdSide.progFull <= (countNext >= uartPkg::RxProgFullThreshold);
        end
    end

    // Head entry always shown
    assign rdSide.rdData = mem[rdPtr];

    countBounded: assert property (
        @(posedge i_Clk) disable iff (!i_rstN)
        count <= uartPkg::FifoDepth
    ) else $error("FIFO occupancy above depth");

endmodule

// File: source/uartFifoIf.sv
`timescale 1ns/100ps

interface uartFifoIf;

    logic wrEn;
    uartPkg::byte_t wrData;
    logic full;

    logic rdEn;
    uartPkg::byte_t rdData;
    logic empty;
    logic progFull;

    // Writer also sees empty so the bus side can report TX done
    modport writer (output wrEn, output wrData, input full, input empty);
    modport reader (output rdEn, input rdData, input empty, input progFull);

    // FIFO's own view of both sides
    modport sink (input wrEn, input wrData, output full);
    modport source (input rdEn, output rdData, output empty, output progFull);

endinterface

// File: source/uartPkg.sv
package uartPkg;

    localparam int ByteBits = 8;
    localparam int ClksBits = 16;
    localparam int AvAddrBits = 30;
    localparam int AvDataBits = 32;
    localparam int AvByteEnBits = 4;

    localparam int FifoDepth = 16;
    localparam int FifoPtrBits = 4;
    localparam int RxProgFullThreshold = 14;

    localparam int PeriphSelBits = 5;
    localparam int RegAddrCtrl = 0;
    localparam int RegAddrData = 1;
    localparam int DefaultClksPerBit = 16;

    // Control and status word layout
    localparam int CtrlClksLsb = 0;
    localparam int CtrlTxEnBit = 16;
    localparam int CtrlRxEnBit = 17;
    localparam int StatTxDoneBit = 18;
    localparam int StatTxFullBit = 19;
    localparam int StatRxAvailBit = 20;
    localparam int CtrlFcEnBit = 21;

    typedef logic [ByteBits-1:0] byte_t;
    typedef logic [ClksBits-1:0] clksPerBit_t;
    typedef logic [AvAddrBits-1:0] avAddr_t;
    typedef logic [AvDataBits-1:0] avData_t;
    typedef logic [AvByteEnBits-1:0] avByteEn_t;
    // One extra bit so a full FIFO reads 16
    typedef logic [FifoPtrBits:0] fifoCount_t;

    typedef enum logic [1:0] {TxIdle, TxStart, TxData, TxStop} txState_t;
    typedef enum logic [1:0] {RxIdle, RxStart, RxData, RxStop} rxState_t;

endpackage

// File: source/uartRx.sv
`timescale 1ns/100ps

module uartRx (
    input  logic                 i_Clk,
    input  logic                 i_rstN,
    input  logic                 i_rxEn,
    input  uartPkg::clksPerBit_t i_clksPerBit,
    input  logic                 i_UartRx,
    uartFifoIf.writer            rxFifo
);

    uartPkg::rxState_t state;
    uartPkg::byte_t shiftReg;
    logic [2:0] bitCnt;
    logic [1:0] rxSync;
    logic rxPrev;
    logic rxLine;
    logic fallEdge;
    logic midTick;

    // Two-flop synchronizer plus edge history
    always_ff @(posedge i_Clk) begin
        if (!i_rstN) begin
            rxSync <= 2'b11;
            rxPrev <= 1'b1;
        end else begin
            rxSync <= {rxSync[0], i_UartRx};
            rxPrev <= rxSync[1];
        end
    end

    assign rxLine = rxSync[1];
    assign fallEdge = rxPrev && !rxLine;

    baudTimer bitTimer_i (
        .i_Clk        (i_Clk),
        .i_rstN       (i_rstN),
        .i_run        (state != uartPkg::RxIdle),
        .i_clksPerBit (i_clksPerBit),
        .o_midTick    (midTick),
        .o_endTick    ()
    );

    // LSB arrives first
    always_ff @(posedge i_Clk) begin
        if (state == uartPkg::RxData && midTick) begin
            shiftReg <= {rxLine, shiftReg[7:1]};
        end
    end

    always_ff @(posedge i_Clk) begin
        if (!i_rstN) begin
            state <= uartPkg::RxIdle;
            bitCnt <= '0;
        end else begin
            case (state)
                uartPkg::RxIdle: begin
                    if (i_rxEn && fallEdge) begin
                        state <= uartPkg::RxStart;
                        bitCnt <= '0;
                    end
                end
                uartPkg::RxStart: begin
                    // Line back high at mid-start is a glitch
                    if (midTick) begin
                        state <= rxLine ? uartPkg::RxIdle : uartPkg::RxData;
                    end
                end
                uartPkg::RxData: begin
                    if (midTick) begin
                        bitCnt <= bitCnt + 1'b1;
                        if (bitCnt == 3'd7) begin
                            state <= uartPkg::RxStop;
                        end
                    end
                end
                uartPkg::RxStop: begin
                    if (midTick) begin
                        state <= uartPkg::RxIdle;
                    end
                end
                default: state <= uartPkg::RxIdle;
            endcase
        end
    end

    // Bad stop bit or full FIFO drops the frame
    assign rxFifo.wrEn = (state == uartPkg::RxStop) && midTick && rxLine && !rxFifo.full;
    assign rxFifo.wrData = shiftReg;

    // Push only in STOP, after all eight data bits were shifted in
    pushOnlyInStop: assert property (
        @(posedge i_Clk) disable iff (!i_rstN)
        rxFifo.wrEn |-> (state == uartPkg::RxStop) && (bitCnt == 3'd0)
    ) else $error("RX push outside stop bit or before eight data bits");

endmodule

// File: source/uartTop.sv
`timescale 1ns/100ps

module uartTop #(
    parameter logic [uartPkg::PeriphSelBits-1:0] PeriphSelVal = '0
) (
    input  logic               i_Clk,
    input  logic               i_rstN,
    input  uartPkg::avAddr_t   i_avAddr,
    input  uartPkg::avByteEn_t i_avByteEn,
    input  logic               i_avRead,
    input  logic               i_avWrite,
    input  uartPkg::avData_t   i_avWriteData,
    output uartPkg::avData_t   o_avReadData,
    output logic               o_UartTx,
    input  logic               i_UartNcts,
    input  logic               i_UartRx,
    output logic               o_UartNrts
);

    uartPkg::clksPerBit_t clksPerBit;
    logic txEn;
    logic rxEn;
    logic fcEn;
    logic txIdle;

    uartFifoIf txFifoBus ();
    uartFifoIf rxFifoBus ();

    uartBusInterface #(
        .PeriphSelVal (PeriphSelVal)
    ) busInterface_i (
        .i_Clk         (i_Clk),
        .i_rstN        (i_rstN),
        .i_avAddr      (i_avAddr),
        .i_avByteEn    (i_avByteEn),
        .i_avRead      (i_avRead),
        .i_avWrite     (i_avWrite),
        .i_avWriteData (i_avWriteData),
        .o_avReadData  (o_avReadData),
        .o_clksPerBit  (clksPerBit),
        .o_txEn        (txEn),
        .o_rxEn        (rxEn),
        .o_fcEn        (fcEn),
        .i_txIdle      (txIdle),
        .txFifo        (txFifoBus),
        .rxFifo        (rxFifoBus)
    );

    uartFifo txFifo_i (.i_Clk(i_Clk), .i_rstN(i_rstN), .wrSide(txFifoBus), .rdSide(txFifoBus));
    uartFifo rxFifo_i (.i_Clk(i_Clk), .i_rstN(i_rstN), .wrSide(rxFifoBus), .rdSide(rxFifoBus));

    uartTx uartTx_i (
        .i_Clk        (i_Clk),
        .i_rstN       (i_rstN),
        .i_txEn       (txEn),
        .i_fcEn       (fcEn),
        .i_clksPerBit (clksPerBit),
        .i_UartNcts   (i_UartNcts),
        .txFifo       (txFifoBus),
        .o_txIdle     (txIdle),
        .o_UartTx     (o_UartTx)
    );

    uartRx uartRx_i (
        .i_Clk        (i_Clk),
        .i_rstN       (i_rstN),
        .i_rxEn       (rxEn),
        .i_clksPerBit (clksPerBit),
        .i_UartRx     (i_UartRx),
        .rxFifo       (rxFifoBus)
    );

    // Ask the far end to pause near RX full
    assign o_UartNrts = fcEn && rxFifoBus.progFull;

endmodule

// File: source/uartTx.sv
`timescale 1ns/100ps

module uartTx (
    input  logic                 i_Clk,
    input  logic                 i_rstN,
    input  logic                 i_txEn,
    input  logic                 i_fcEn,
    input  uartPkg::clksPerBit_t i_clksPerBit,
    input  logic                 i_UartNcts,
    uartFifoIf.reader            txFifo,
    output logic                 o_txIdle,
    output logic                 o_UartTx
);

    uartPkg::txState_t state;
    uartPkg::byte_t shiftReg;
    logic [2:0] bitCnt;
    logic [1:0] ctsSync;
    logic ctsOk;
    logic startFrame;
    logic endTick;

    // nCTS comes from off chip
    always_ff @(posedge i_Clk) begin
        if (!i_rstN) begin
            ctsSync <= 2'b11;
        end else begin
            ctsSync <= {ctsSync[0], i_UartNcts};
        end
    end

    assign ctsOk = !i_fcEn || !ctsSync[1];
    assign startFrame = (state == uartPkg::TxIdle) && i_txEn && !txFifo.empty && ctsOk;
    // Pop as the frame starts
    assign txFifo.rdEn = startFrame;
    assign o_txIdle = (state == uartPkg::TxIdle);

    baudTimer bitTimer_i (
        .i_Clk        (i_Clk),
        .i_rstN       (i_rstN),
        .i_run        (!o_txIdle),
        .i_clksPerBit (i_clksPerBit),
        .o_midTick    (),
        .o_endTick    (endTick)
    );

    always_ff @(posedge i_Clk) begin
        if (startFrame) begin
            shiftReg <= txFifo.rdData;
        end else if (state == uartPkg::TxData && endTick) begin
            shiftReg <= shiftReg >> 1;
        end
    end

    always_ff @(posedge i_Clk) begin
        if (!i_rstN) begin
            state <= uartPkg::TxIdle;
            bitCnt <= '0;
            o_UartTx <= 1'b1;
        end else begin
            case (state)
                uartPkg::TxIdle: begin
                    if (startFrame) begin
                        state <= uartPkg::TxStart;
                        bitCnt <= '0;
                        o_UartTx <= 1'b0;
                    end
                end
                uartPkg::TxStart: begin
                    if (endTick) begin
                        state <= uartPkg::TxData;
                        o_UartTx <= shiftReg[0];
                    end
                end
                uartPkg::TxData: begin
                    if (endTick) begin
                        if (bitCnt == 3'd7) begin
                            state <= uartPkg::TxStop;
                            o_UartTx <= 1'b1;
                        end else begin
                            bitCnt <= bitCnt + 1'b1;
                            // Next bit before the shift lands
                            o_UartTx <= shiftReg[1];
                        end
                    end
                end
                uartPkg::TxStop: begin
                    if (endTick) begin
                        state <= uartPkg::TxIdle;
                    end
                end
                default: state <= uartPkg::TxIdle;
            endcase
        end
    end

    idleLineHigh: assert property (
        @(posedge i_Clk) disable iff (!i_rstN)
        (state == uartPkg::TxIdle) |-> o_UartTx
    ) else $error("TX line low while idle");

endmodule
